//--- filelist.f
dmi_pkg.sv
dmi_axil_port.sv
dmi_decode.sv
dmi_stage.sv
dmi_execute.sv
dmi_result.sv
dmi_bridge_top.sv
dmi_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and pass only if the testbench reports success
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f filelist.f --top-module dmi_tb -o dmi_sim \
   && ./obj_dir/dmi_sim | tee /dev/stderr | grep -x "sim passed" > /dev/null \
   && echo "run.sh: simulation passed" \
   || { echo "run.sh: simulation failed"; exit 1; }

//--- dmi_tb.sv
// Assumes core_regs = 16 and a uncore model that answers in the strobe cycle
`timescale 1ns/1ps
`default_nettype none

module dmi_tb;

   import dmi_pkg::*;

   localparam int core_regs  = 16;
   localparam int n_trans    = 190;   // Upper bound on requests issued
   localparam int max_cycles = n_trans * 20 + 100;

   logic                   clk, rst_n, uncore_on;
   logic                   awvalid, awready, wvalid, wready, arvalid, arready;
   logic [axil_addr_w-1:0] awaddr, araddr;
   logic                   bvalid, bready, rvalid, rready;
   axil_resp_e             bresp, rresp;
   dmi_data_t              wdata, rdata, uc_rdata, uc_wdata, uc_wdata_exp;
   logic                   uc_en, uc_wr_en, uc_wr_exp, uc_allowed;
   dmi_addr_t              uc_addr, uc_addr_exp, a_r;
   logic                   lat_mode, rand_ready, fire_d, exp_valid;
   logic [31:0]            rnd, rnd2, ready_rnd;
   dmi_data_t              model_regs [core_regs];   // Expected core register bank
   dmi_rsp_t               exp_q [$];                // Responses still owed, oldest first
   dmi_rsp_t               exp_head;
   integer                 seed, errors, err_mark, n_tests, n_failed, uc_seen, uc_expected;
   string                  test_name;

   dmi_bridge_top #(.core_regs(core_regs)) DUT (
      .clk(clk), .rst_n(rst_n), .dmi_uncore_enable(uncore_on),
      .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
      .wvalid(wvalid), .wready(wready), .wdata(wdata),
      .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .arvalid(arvalid), .arready(arready), .araddr(araddr),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
      .dmi_uncore_en(uc_en), .dmi_uncore_wr_en(uc_wr_en),
      .dmi_uncore_addr(uc_addr), .dmi_uncore_wdata(uc_wdata),
      .dmi_uncore_rdata(uc_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // ************************************************************
   // Reference model and drivers
   // ************************************************************
   function automatic dmi_rsp_t predict(input logic wr, input dmi_addr_t a, input dmi_data_t d);
      dmi_rsp_t r;
      r.is_write = wr;
      r.rdata    = '0;
      r.resp     = resp_okay;
      if (uncore_on && a[6]) begin
         uc_addr_exp  = a;
         uc_wr_exp    = wr;
         uc_wdata_exp = d;
         uc_expected  = uc_expected + 1;
         if (!wr) r.rdata = uc_rdata;
      end else if (a < 7'(core_regs)) begin
         if (wr) model_regs[a[3:0]] = d;
         else r.rdata = model_regs[a[3:0]];
      end else begin
         r.resp = resp_slverr;   // Unmapped
      end
      return r;
   endfunction

   // Returns once the handshake is due on the next rising edge
   task automatic issue(input logic wr, input dmi_addr_t a, input dmi_data_t d);
      @(negedge clk);
      awvalid = wr;
      wvalid  = wr;
      arvalid = !wr;
      awaddr  = wr ? {a, 2'b00} : {~a, 2'b11};   // Idle channel carries a different address
      araddr  = wr ? {~a, 2'b11} : {a, 2'b00};
      wdata   = d;
      #1;
      while (!(wr ? awready : arready)) begin
         @(negedge clk);
         #1;
      end
      exp_q.push_back(predict(wr, a, d));
   endtask

   task automatic drain();
      @(negedge clk);
      awvalid = 1'b0;
      wvalid  = 1'b0;
      arvalid = 1'b0;
      #3;
      while (exp_q.size() != 0) begin
         @(negedge clk);
         #3;
      end
   endtask

   task automatic start_test(input string name);
      test_name = name;
      err_mark  = errors;
   endtask

   task automatic end_test();
      if (uc_seen != uc_expected) begin
         errors = errors + 1;
         $display("Fail %s: uncore strobes expected %0d, actual %0d",
                  test_name, uc_expected, uc_seen);
      end
      n_tests = n_tests + 1;
      if (errors != err_mark) n_failed = n_failed + 1;
      $display("test %s: %0d errors", test_name, errors - err_mark);
   endtask

   // Head of the expected queue, stable from just after each falling edge
   initial begin
      fire_d    = 1'b0;
      exp_valid = 1'b0;
      exp_head  = '0;
      uc_seen   = 0;
      forever begin
         @(negedge clk);
         if (fire_d && exp_q.size() != 0) void'(exp_q.pop_front());
         #2;
         exp_valid = exp_q.size() != 0;
         if (exp_valid) exp_head = exp_q[0];
         fire_d = (bvalid && bready) || (rvalid && rready);   // Transfer on coming edge
         if (uc_en) uc_seen = uc_seen + 1;
      end
   end

   initial begin
      bready = 1'b1;
      rready = 1'b1;
      forever begin
         @(negedge clk);
         if (rand_ready) begin
            ready_rnd = $random(seed);
            bready    = ready_rnd[0];
            rready    = ready_rnd[1];
         end else begin
            bready = 1'b1;
            rready = 1'b1;
         end
      end
   end

   // ************************************************************
   // Checks
   // ************************************************************
   a_reset_quiet : assert property (@(posedge clk) rst_n && !$past(rst_n) |->
      !bvalid && !rvalid && !uc_en && !uc_wr_en)
      else begin
         errors++;
         $display("Reset left a response or uncore strobe active");
      end

   // AW and W are taken on the same edge
   a_aw_w_pair : assert property (@(posedge clk) disable iff (!rst_n)
      awready == wready)
      else begin
         errors++;
         $display("%s: awready and wready did not rise together", test_name);
      end

   a_order : assert property (@(posedge clk) disable iff (!rst_n)
      (bvalid && bready) || (rvalid && rready) |-> exp_valid && exp_head.is_write == bvalid)
      else begin
         errors++;
         $display("%s: response on the wrong channel or with none outstanding", test_name);
      end

   a_bresp : assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && bready |-> bresp == exp_head.resp)
      else begin
         errors++;
         $display("Fail %s: bresp expected %0d, actual %0d", test_name, exp_head.resp, bresp);
      end

   a_rdata : assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && rready |-> rdata == exp_head.rdata && rresp == exp_head.resp)
      else begin
         errors++;
         $display("Fail %s: rdata/rresp expected %h/%0d, actual %h/%0d",
                  test_name, exp_head.rdata, exp_head.resp, rdata, rresp);
      end

   a_uncore_port : assert property (@(posedge clk) disable iff (!rst_n)
      uc_en |-> uc_allowed && uc_addr == uc_addr_exp && uc_wr_en == uc_wr_exp &&
                (!uc_wr_exp || uc_wdata == uc_wdata_exp))
      else begin
         errors++;
         $display("Fail %s: uncore wr/addr/wdata expected %b/%h/%h, actual %b/%h/%h",
                  test_name, uc_wr_exp, uc_addr_exp, uc_wdata_exp, uc_wr_en, uc_addr, uc_wdata);
      end

   a_uncore_pulse : assert property (@(posedge clk) disable iff (!rst_n)
      uc_en |=> !uc_en)
      else begin
         errors++;
         $display("%s: uncore strobe held longer than one cycle", test_name);
      end

   // Single read into an idle pipeline
   a_latency : assert property (@(posedge clk) disable iff (!rst_n)
      lat_mode && $past(arvalid && arready, 2) |-> rvalid)
      else begin
         errors++;
         $display("Fail %s: rvalid expected 1, actual %b", test_name, rvalid);
      end

   a_not_early : assert property (@(posedge clk) disable iff (!rst_n)
      lat_mode && $past(arvalid && arready) |-> !rvalid)
      else begin
         errors++;
         $display("Fail %s: rvalid expected 0, actual %b", test_name, rvalid);
      end

   // ************************************************************
   // Stimulus
   // ************************************************************
   initial begin
      seed = 83;
      errors = 0;
      n_tests = 0;
      n_failed = 0;
      uc_expected = 0;
      rst_n = 1'b0;
      uncore_on = 1'b0;
      awvalid = 1'b0;
      wvalid = 1'b0;
      arvalid = 1'b0;
      awaddr = '0;
      araddr = '0;
      wdata = '0;
      uc_rdata = '0;
      uc_allowed = 1'b0;
      uc_addr_exp = '0;
      uc_wr_exp = 1'b0;
      uc_wdata_exp = '0;
      lat_mode = 1'b0;
      rand_ready = 1'b0;
      for (int i = 0; i < core_regs; i++) model_regs[i] = '0;
      repeat (16) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      start_test("reset");
      for (int i = 0; i < core_regs; i++) issue(1'b0, 7'(i), '0);
      drain();
      end_test();

      start_test("core_regs");
      for (int i = 0; i < 40; i++) begin
         rnd  = $random(seed);
         rnd2 = $random(seed);
         issue(1'b1, {3'b000, rnd[3:0]}, rnd2);
      end
      for (int i = 0; i < core_regs; i++) issue(1'b0, 7'(i), '0);
      drain();
      end_test();

      start_test("out_of_range");
      for (int i = 0; i < 20; i++) begin
         rnd  = $random(seed);
         rnd2 = $random(seed);
         a_r  = (rnd[6:0] < 7'd16) ? rnd[6:0] + 7'd16 : rnd[6:0];
         issue(rnd[7], a_r, rnd2);
      end
      for (int i = 0; i < core_regs; i++) issue(1'b0, 7'(i), '0);
      drain();
      end_test();

      start_test("uncore");
      @(negedge clk);
      uncore_on  = 1'b1;
      uc_allowed = 1'b1;
      for (int i = 0; i < 8; i++) begin
         rnd  = $random(seed);
         rnd2 = $random(seed);
         @(negedge clk);
         uc_rdata = rnd2 ^ 32'h5a5a_0000;   // Read data seen on the strobe
         issue(rnd[6], {1'b1, rnd[5:0]}, rnd2);
         drain();
      end
      rnd = $random(seed);
      issue(1'b1, 7'd5, rnd);
      issue(1'b0, 7'd5, '0);
      issue(1'b0, 7'd20, '0);   // Still unmapped with the uncore on
      drain();
      @(negedge clk);
      uncore_on  = 1'b0;
      uc_allowed = 1'b0;
      end_test();

      start_test("backpressure");
      rand_ready = 1'b1;
      for (int i = 0; i < 60; i++) begin
         rnd  = $random(seed);
         rnd2 = $random(seed);
         issue(rnd[0], {2'b00, rnd[5:1]}, rnd2);
      end
      drain();
      rand_ready = 1'b0;
      end_test();

      start_test("latency");
      lat_mode = 1'b1;
      issue(1'b0, 7'd3, '0);
      drain();
      lat_mode = 1'b0;
      end_test();

      $display("tests %0d, tests failed %0d, errors %0d", n_tests, n_failed, errors);
      if (errors == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (max_cycles) @(posedge clk);
      $display("Run did not finish within %0d cycles, %0d responses outstanding",
               max_cycles, exp_q.size());
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- dmi_bridge_top.sv
// Single clock; two items in flight at most, response two cycles after request acceptance
`timescale 1ns/1ps
`default_nettype none

module dmi_bridge_top #(
   parameter int core_regs = 16
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            dmi_uncore_enable,

   // AXI4-Lite slave
   input  logic                            awvalid,
   output logic                            awready,
   input  logic [dmi_pkg::axil_addr_w-1:0] awaddr,
   input  logic                            wvalid,
   output logic                            wready,
   input  dmi_pkg::dmi_data_t              wdata,
   output logic                            bvalid,
   input  logic                            bready,
   output dmi_pkg::axil_resp_e             bresp,
   input  logic                            arvalid,
   output logic                            arready,
   input  logic [dmi_pkg::axil_addr_w-1:0] araddr,
   output logic                            rvalid,
   input  logic                            rready,
   output dmi_pkg::dmi_data_t              rdata,
   output dmi_pkg::axil_resp_e             rresp,

   // Uncore port
   output logic                            dmi_uncore_en,
   output logic                            dmi_uncore_wr_en,
   output dmi_pkg::dmi_addr_t              dmi_uncore_addr,
   output dmi_pkg::dmi_data_t              dmi_uncore_wdata,
   input  dmi_pkg::dmi_data_t              dmi_uncore_rdata
);

   import dmi_pkg::*;

   logic     req_valid, req_ready;
   dmi_req_t req;
   logic     dec_valid, dec_ready;   // Decode to dec_stage
   dmi_dec_t dec;
   logic     ex_valid, ex_ready;     // dec_stage to execute
   dmi_dec_t ex_dec;
   logic     ex_rsp_valid, ex_rsp_ready;
   dmi_rsp_t ex_rsp;
   logic     res_valid, res_ready;   // rsp_stage to result
   dmi_rsp_t res_rsp;

   dmi_axil_port u_port (.*);

   dmi_decode #(.core_regs(core_regs)) u_decode (
      .clk(clk), .rst_n(rst_n), .uncore_enable(dmi_uncore_enable),
      .in_valid(req_valid), .in_ready(req_ready), .req(req),
      .out_valid(dec_valid), .out_ready(dec_ready), .dec(dec)
   );

   dmi_stage #(.payload_t(dmi_dec_t)) dec_stage (
      .clk(clk), .rst_n(rst_n),
      .in_valid(dec_valid), .in_ready(dec_ready), .in_data(dec),
      .out_valid(ex_valid), .out_ready(ex_ready), .out_data(ex_dec)
   );

   dmi_execute #(.core_regs(core_regs)) u_execute (
      .clk(clk), .rst_n(rst_n),
      .in_valid(ex_valid), .in_ready(ex_ready), .dec(ex_dec),
      .out_valid(ex_rsp_valid), .out_ready(ex_rsp_ready), .rsp(ex_rsp),
      .dmi_uncore_en(dmi_uncore_en), .dmi_uncore_wr_en(dmi_uncore_wr_en),
      .dmi_uncore_addr(dmi_uncore_addr), .dmi_uncore_wdata(dmi_uncore_wdata),
      .dmi_uncore_rdata(dmi_uncore_rdata)
   );

   dmi_stage #(.payload_t(dmi_rsp_t)) rsp_stage (
      .clk(clk), .rst_n(rst_n),
      .in_valid(ex_rsp_valid), .in_ready(ex_rsp_ready), .in_data(ex_rsp),
      .out_valid(res_valid), .out_ready(res_ready), .out_data(res_rsp)
   );

   dmi_result u_result (
      .in_valid(res_valid), .in_ready(res_ready), .rsp(res_rsp),
      .bvalid(bvalid), .bready(bready), .bresp(bresp),
      .rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
   );

endmodule

`default_nettype wire

//--- dmi_result.sv
// Purely combinational; B or R only ever carries the oldest response, in request order
`timescale 1ns/1ps
`default_nettype none

module dmi_result (
   input  logic                in_valid,
   output logic                in_ready,
   input  dmi_pkg::dmi_rsp_t   rsp,

   // Write response
   output logic                bvalid,
   input  logic                bready,
   output dmi_pkg::axil_resp_e bresp,

   // Read response
   output logic                rvalid,
   input  logic                rready,
   output dmi_pkg::dmi_data_t  rdata,
   output dmi_pkg::axil_resp_e rresp
);

   // ************************************************************
   // Channel steering
   // ************************************************************
   assign bvalid = in_valid && rsp.is_write;
   assign rvalid = in_valid && !rsp.is_write;

   // Head blocks until its own channel takes it
   assign in_ready = rsp.is_write ? bready : rready;

   assign bresp = rsp.resp;
   assign rresp = rsp.resp;
   assign rdata = rsp.rdata;

   // No clock at this level, so checked on every evaluation
   always_comb begin
      a_one_channel : assert (!(bvalid && rvalid))
         else $error("B and R valid together");
   end

endmodule

`default_nettype wire

//--- dmi_execute.sv
// core_regs must be 2 to 128; uncore rdata is taken combinationally while the strobe is up
`timescale 1ns/1ps
`default_nettype none

module dmi_execute #(
   parameter int core_regs = 16
) (
   input  logic               clk,
   input  logic               rst_n,

   input  logic               in_valid,
   output logic               in_ready,
   input  dmi_pkg::dmi_dec_t  dec,

   output logic               out_valid,
   input  logic               out_ready,
   output dmi_pkg::dmi_rsp_t  rsp,

   // Uncore port
   output logic               dmi_uncore_en,
   output logic               dmi_uncore_wr_en,
   output dmi_pkg::dmi_addr_t dmi_uncore_addr,
   output dmi_pkg::dmi_data_t dmi_uncore_wdata,
   input  dmi_pkg::dmi_data_t dmi_uncore_rdata
);

   import dmi_pkg::*;

   localparam int idx_w = (core_regs > 1) ? $clog2(core_regs) : 1;

   dmi_data_t        regs [core_regs];   // Core debug register bank
   logic             fire;
   logic [idx_w-1:0] idx;

   assign fire      = in_valid && out_ready;   // Access happens on this edge
   assign in_ready  = out_ready;
   assign out_valid = in_valid;
   assign idx       = dec.req.addr[idx_w-1:0];

   // ************************************************************
   // Core register bank
   // ************************************************************
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         regs <= '{default: '0};
      end else if (fire && dec.target == tgt_core && dec.req.is_write) begin
         regs[idx] <= dec.req.wdata;
      end
   end

   // ************************************************************
   // Uncore drive, one strobe per item
   // ************************************************************
   assign dmi_uncore_en    = fire && dec.target == tgt_uncore;
   assign dmi_uncore_wr_en = dmi_uncore_en && dec.req.is_write;
   assign dmi_uncore_addr  = dec.req.addr;
   assign dmi_uncore_wdata = dec.req.wdata;

   // Response
   always_comb begin
      rsp.is_write = dec.req.is_write;
      rsp.rdata    = '0;
      rsp.resp     = resp_okay;
      case (dec.target)
         tgt_core: begin
            if (!dec.req.is_write) rsp.rdata = regs[idx];
         end
         tgt_uncore: begin
            if (!dec.req.is_write) rsp.rdata = dmi_uncore_rdata;
         end
         default: rsp.resp = resp_slverr;   // Nothing touched
      endcase
   end

   a_wr_needs_en : assert property (@(posedge clk) disable iff (!rst_n)
      dmi_uncore_wr_en |-> dmi_uncore_en)
      else $error("uncore write strobe without enable");

endmodule

`default_nettype wire

//--- dmi_stage.sv
// One-entry register slice, full throughput, ready path is combinational from out_ready
`timescale 1ns/1ps
`default_nettype none

module dmi_stage #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,

   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,

   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   // Take new data when empty or emptying this cycle
   assign in_ready = !out_valid || out_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out_data <= in_data;   // Payload only
      end
   end

   a_hold : assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
      else $error("stage output changed while stalled");

endmodule

`default_nettype wire

//--- dmi_decode.sv
// Combinational target select; core_regs addresses above the uncore window need uncore off
`timescale 1ns/1ps
`default_nettype none

module dmi_decode #(
   parameter int core_regs = 16
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              uncore_enable,

   input  logic              in_valid,
   output logic              in_ready,
   input  dmi_pkg::dmi_req_t req,

   output logic              out_valid,
   input  logic              out_ready,
   output dmi_pkg::dmi_dec_t dec
);

   import dmi_pkg::*;

   // Handshake passes straight through
   assign out_valid = in_valid;
   assign in_ready  = out_ready;

   always_comb begin
      dec.req = req;
      if (uncore_enable && req.addr[uncore_sel_bit]) begin
         dec.target = tgt_uncore;
      end else if (int'(req.addr) < core_regs) begin
         dec.target = tgt_core;
      end else begin
         dec.target = tgt_none;   // Answers with SLVERR later
      end
   end

   a_no_uncore_when_off : assert property (@(posedge clk) disable iff (!rst_n)
      out_valid && !uncore_enable |-> dec.target != tgt_uncore)
      else $error("uncore target while uncore disabled");

endmodule

`default_nettype wire

//--- dmi_axil_port.sv
// Reads win over writes; AW and W must be presented together, no WSTRB or PROT support
`timescale 1ns/1ps
`default_nettype none

module dmi_axil_port (
   input  logic                           clk,
   input  logic                           rst_n,

   // Write address and data
   input  logic                           awvalid,
   output logic                           awready,
   input  logic [dmi_pkg::axil_addr_w-1:0] awaddr,
   input  logic                           wvalid,
   output logic                           wready,
   input  dmi_pkg::dmi_data_t             wdata,

   // Read address
   input  logic                           arvalid,
   output logic                           arready,
   input  logic [dmi_pkg::axil_addr_w-1:0] araddr,

   // Request towards decode
   output logic                           req_valid,
   input  logic                           req_ready,
   output dmi_pkg::dmi_req_t              req
);

   import dmi_pkg::*;

   logic wr_lock;   // Write already offered and stalled
   logic sel_rd;
   logic sel_wr;

   // ************************************************************
   // Arbitration
   // ************************************************************
   // A stalled write keeps the slot, so a late read cannot swap
   // the payload under a valid that is already up
   assign sel_rd = arvalid && !wr_lock;
   assign sel_wr = wr_lock || (!arvalid && awvalid && wvalid);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wr_lock <= 1'b0;
      end else begin
         wr_lock <= sel_wr && !req_ready;
      end
   end

   assign req_valid = sel_rd || sel_wr;

   // Ready only toward the channel that owns the slot
   assign arready = req_ready && sel_rd;
   assign awready = req_ready && sel_wr;
   assign wready  = req_ready && sel_wr;   // Same cycle as awready

   // ************************************************************
   // Request build
   // ************************************************************
   always_comb begin
      req.is_write = sel_wr;
      if (sel_wr) begin
         req.addr  = awaddr[axil_addr_w-1:2];
         req.wdata = wdata;
      end else begin
         req.addr  = araddr[axil_addr_w-1:2];
         req.wdata = '0;
      end
   end

   // Offered request stays put until decode takes it
   a_req_held : assert property (@(posedge clk) disable iff (!rst_n)
      req_valid && !req_ready |=> req_valid && $stable(req))
      else $error("request changed while stalled");

endmodule

`default_nettype wire

//--- dmi_pkg.sv
// Widths and structs fixed for a 7-bit DMI space over a 9-bit AXI4-Lite byte address
`default_nettype none

package dmi_pkg;

   // ************************************************************
   // Widths
   // ************************************************************
   localparam int dmi_addr_w     = 7;
   localparam int dmi_data_w     = 32;
   localparam int uncore_sel_bit = 6;  // DMI address bit that picks the uncore
   localparam int axil_addr_w    = 9;  // DMI word address sits in bits 8:2

   typedef logic [dmi_addr_w-1:0] dmi_addr_t;
   typedef logic [dmi_data_w-1:0] dmi_data_t;

   // AXI response codes, only the two this bridge returns
   typedef enum logic [1:0] {
      resp_okay   = 2'b00,
      resp_slverr = 2'b10
   } axil_resp_e;

   typedef enum logic [1:0] {
      tgt_core   = 2'd0,
      tgt_uncore = 2'd1,
      tgt_none   = 2'd2   // Unmapped address
   } dmi_target_e;

   // ************************************************************
   // Pipeline payloads
   // ************************************************************
   typedef struct packed {
      logic      is_write;
      dmi_addr_t addr;
      dmi_data_t wdata;     // Zero on reads
   } dmi_req_t;

   typedef struct packed {
      dmi_req_t    req;
      dmi_target_e target;
   } dmi_dec_t;

   typedef struct packed {
      logic       is_write;
      dmi_data_t  rdata;    // Zero on writes and errors
      axil_resp_e resp;
   } dmi_rsp_t;

endpackage

`default_nettype wire
